/* src/mem_geom_pkg.sv */
//----------------------------------------------------------------------------
// memory geometry for the SDRAM traffic generator
// local port widths, burst shape, sweep limits and the address struct
//----------------------------------------------------------------------------
`default_nettype none

package mem_geom_pkg;

  // local data port, one byte per lane
  localparam int data_width = 32;
  localparam int lane_count = data_width / 8;

  // address field widths
  localparam int bank_width = 2;
  localparam int row_width  = 13;
  localparam int col_width  = 10;
  localparam int size_width = 7;

  // two beats per burst, so the column moves four per burst
  localparam int burst_len = 2;
  localparam int col_step  = 4;

  // inclusive sweep limits, 5 x 4 x 4 bursts per pass
  localparam int max_col  = 16;
  localparam int max_row  = 3;
  localparam int max_bank = 3;

  typedef struct packed {
    logic [bank_width-1:0] bank;
    logic [row_width-1:0]  row;
    logic [col_width-1:0]  col;
  } mem_addr_t;

endpackage

`default_nettype wire

/* src/traffic_pkg.sv */
//----------------------------------------------------------------------------
// traffic generator types
// controller states, local command, beat strobes, status and LFSR constants
//----------------------------------------------------------------------------
`default_nettype none

package traffic_pkg;

  typedef enum logic [2:0] {
    idle,
    seq_write,
    seq_read,
    mask_zero,
    mask_write,
    mask_read,
    drain,
    done
  } traffic_state_t;

  // local command port of the controller
  typedef struct packed {
    logic                                   write_req;
    logic                                   read_req;
    logic                                   burst_begin;
    mem_geom_pkg::mem_addr_t                addr;
    logic [mem_geom_pkg::size_width-1:0]    size;
    logic [mem_geom_pkg::lane_count-1:0]    be;
    logic [mem_geom_pkg::data_width-1:0]    wdata;
  } local_cmd_t;

  // accepted transfers, one cycle each
  typedef struct packed {
    logic wr_beat;
    logic rd_accept;
    logic rd_beat;
  } beat_evt_t;

  typedef struct packed {
    logic seq_mode;
    logic mask_mode;
    logic complete;
  } test_status_t;

  // per-lane LFSR seeds, lane 0 in the low byte
  localparam logic [3:0][7:0] lane_seeds = {8'd31, 8'd21, 8'd11, 8'd1};

  // x^8 + x^6 + x^5 + x^4
  localparam logic [7:0] lfsr_taps = 8'b1011_1000;

endpackage

`default_nettype wire

/* src/traffic_fsm.sv */
//----------------------------------------------------------------------------
// traffic FSM
// runs the sequential-address test then the byte-mask test, then stops
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module traffic_fsm (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      local_ready,
  input  logic                      local_rdata_valid,
  input  logic                      beat_last,
  input  logic                      sweep_end,
  input  logic                      reads_idle,
  output traffic_pkg::local_cmd_t   cmd_ctl,
  output traffic_pkg::beat_evt_t    evt,
  output logic                      sweep_restart,
  output logic                      pattern_restart,
  output logic                      mask_restart,
  output logic                      zero_fill,
  output traffic_pkg::test_status_t status
);

  import mem_geom_pkg::*;
  import traffic_pkg::*;

  traffic_state_t state;
  logic           write_req;
  logic           read_req;
  logic           burst_begin;
  logic           seq_mode;
  logic           mask_mode;
  logic           complete;
  logic           wr_end;
  logic           mask_begin;

  // the only place local_ready is looked at
  assign evt.wr_beat   = write_req & local_ready;
  assign evt.rd_accept = read_req & local_ready;
  assign evt.rd_beat   = local_rdata_valid;

  // last write of a pass, the next pass starts from a clean sweep
  assign wr_end     = evt.wr_beat & sweep_end;
  assign mask_begin = (state == drain) & reads_idle & ~mask_mode;

  assign sweep_restart   = (state == idle) | mask_begin | wr_end;
  assign pattern_restart = (state == idle) | wr_end;
  assign mask_restart    = wr_end & mask_mode;
  assign zero_fill       = (state == mask_zero);

  always_comb
  begin
    cmd_ctl             = '0;
    cmd_ctl.write_req   = write_req;
    cmd_ctl.read_req    = read_req;
    cmd_ctl.burst_begin = burst_begin;
    cmd_ctl.size        = size_width'(burst_len);
  end

  assign status.seq_mode  = seq_mode;
  assign status.mask_mode = mask_mode;
  assign status.complete  = complete;

  //--------------------------------------------------------------------------
  // test sequencing
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= idle;
      write_req   <= 1'b0;
      read_req    <= 1'b0;
      burst_begin <= 1'b0;
      seq_mode    <= 1'b0;
      mask_mode   <= 1'b0;
      complete    <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          seq_mode    <= 1'b1;
          state       <= seq_write;
        end
        seq_write, mask_zero, mask_write:
        begin
          // mask_write is entered with write_req low for one cycle
          if (!write_req)
          begin
            write_req   <= 1'b1;
            burst_begin <= 1'b1;
          end
          else if (evt.wr_beat)
          begin
            burst_begin <= beat_last;
            if (sweep_end)
            begin
              write_req   <= 1'b0;
              burst_begin <= 1'b1;
              if (state == mask_zero)
                state <= mask_write;
              else
              begin
                read_req <= 1'b1;
                state    <= (state == seq_write) ? seq_read : mask_read;
              end
            end
          end
        end
        seq_read, mask_read:
        begin
          // every read request is its own burst
          if (evt.rd_accept && sweep_end)
          begin
            read_req    <= 1'b0;
            burst_begin <= 1'b0;
            state       <= drain;
          end
        end
        drain:
        begin
          if (reads_idle)
          begin
            if (mask_mode)
            begin
              mask_mode <= 1'b0;
              complete  <= 1'b1;
              state     <= done;
            end
            else
            begin
              seq_mode    <= 1'b0;
              mask_mode   <= 1'b1;
              write_req   <= 1'b1;
              burst_begin <= 1'b1;
              state       <= mask_zero;
            end
          end
        end
        done:
        begin
          state <= done;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/addr_sweep_counter.sv */
//----------------------------------------------------------------------------
// address sweep counter
// column, row, bank sweep plus burst beat and outstanding read counts
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module addr_sweep_counter (
  input  logic                    clk,
  input  logic                    reset_n,
  input  traffic_pkg::beat_evt_t  evt,
  input  logic                    read_pass,
  input  logic                    sweep_restart,
  output mem_geom_pkg::mem_addr_t addr,
  output logic                    beat_last,
  output logic                    sweep_end,
  output logic                    reads_idle
);

  import mem_geom_pkg::*;
  import traffic_pkg::*;

  logic [size_width-1:0] beat_cnt;
  logic [7:0]            reads_out;
  logic                  at_max;
  logic                  addr_step;

  assign beat_last = (beat_cnt == size_width'(burst_len - 1));
  assign at_max    = (addr.col == col_width'(max_col)) &&
                     (addr.row == row_width'(max_row)) &&
                     (addr.bank == bank_width'(max_bank));

  // a read consumes its address at once, a write only on its last beat
  assign sweep_end = at_max & (read_pass | beat_last);
  assign addr_step = (evt.wr_beat & beat_last) | evt.rd_accept;

  assign reads_idle = (reads_out == '0);

  //--------------------------------------------------------------------------
  // address and beat count
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr     <= '0;
      beat_cnt <= '0;
    end
    else if (sweep_restart)
    begin
      addr     <= '0;
      beat_cnt <= '0;
    end
    else
    begin
      if (evt.wr_beat)
        beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
      if (addr_step)
      begin
        if (addr.col >= col_width'(max_col))
        begin
          addr.col <= '0;
          if (addr.row == row_width'(max_row))
          begin
            addr.row  <= '0;
            addr.bank <= (addr.bank == bank_width'(max_bank)) ? '0 : addr.bank + 1'b1;
          end
          else
            addr.row <= addr.row + 1'b1;
        end
        else
          addr.col <= addr.col + col_width'(col_step);
      end
    end
  end

  // outstanding read beats
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      reads_out <= '0;
    else if (evt.rd_accept && evt.rd_beat)
      reads_out <= reads_out + 8'(burst_len - 1);
    else if (evt.rd_accept)
      reads_out <= reads_out + 8'(burst_len);
    else if (evt.rd_beat && !reads_idle)
      reads_out <= reads_out - 1'b1;
  end

endmodule

`default_nettype wire

/* src/pattern_gen.sv */
//----------------------------------------------------------------------------
// pattern generator
// one 8-bit LFSR per byte lane and the walking byte enable
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pattern_gen (
  input  logic                                clk,
  input  logic                                reset_n,
  input  traffic_pkg::beat_evt_t              evt,
  input  logic                                pattern_restart,
  input  logic                                mask_restart,
  input  logic                                zero_fill,
  input  logic                                mask_mode,
  output logic [mem_geom_pkg::data_width-1:0] lane_data,
  output logic [mem_geom_pkg::lane_count-1:0] be
);

  import mem_geom_pkg::*;
  import traffic_pkg::*;

  logic beat_step;

  // zero writes do not consume pattern data
  assign beat_step = (evt.wr_beat & ~zero_fill) | evt.rd_beat;

  //--------------------------------------------------------------------------
  // lane LFSRs
  //--------------------------------------------------------------------------
  for (genvar i = 0; i < lane_count; i++)
  begin : g_lane
    logic [7:0] lfsr;

    always_ff @(posedge clk or negedge reset_n)
    begin
      if (!reset_n)
        lfsr <= lane_seeds[i];
      else if (pattern_restart)
        lfsr <= lane_seeds[i];
      else if (beat_step)
        lfsr <= {lfsr[6:0], ^(lfsr & lfsr_taps)};
    end

    assign lane_data[i*8 +: 8] = lfsr;
  end

  // walking enable, one lane per beat in the mask test
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (mask_restart)
      be <= lane_count'(1);
    else if (!mask_mode || zero_fill)
      be <= '1;
    else if (beat_step)
      be <= {be[lane_count-2:0], be[lane_count-1]};
  end

endmodule

`default_nettype wire

/* src/read_checker.sv */
//----------------------------------------------------------------------------
// read checker
// per-lane compare of read data against the regenerated pattern
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module read_checker (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                rd_beat,
  input  logic [mem_geom_pkg::data_width-1:0] lane_data,
  input  logic [mem_geom_pkg::lane_count-1:0] be,
  input  logic [mem_geom_pkg::data_width-1:0] local_rdata,
  output logic [mem_geom_pkg::lane_count-1:0] pnf_per_byte,
  output logic                                pnf_persist
);

  import mem_geom_pkg::*;

  logic [lane_count-1:0] compare;
  logic [lane_count-1:0] compare_q;
  logic [lane_count-1:0] compare_valid;
  logic                  rd_beat_q;
  logic                  seen;
  logic                  persist_q;

  // disabled lanes are expected to read back as zero
  for (genvar i = 0; i < lane_count; i++)
  begin : g_cmp
    assign compare[i] = ((lane_data[i*8 +: 8] & {8{be[i]}}) == local_rdata[i*8 +: 8]);
  end

  //--------------------------------------------------------------------------
  // three stage result pipeline
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_q     <= '1;
      rd_beat_q     <= 1'b0;
      compare_valid <= '1;
      seen          <= 1'b0;
      persist_q     <= 1'b0;
      pnf_per_byte  <= '1;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      compare_q <= compare;
      rd_beat_q <= rd_beat;
      if (rd_beat_q)
      begin
        compare_valid <= compare_q;
        seen          <= 1'b1;
        // once low, stays low
        persist_q     <= (&compare_q) & (persist_q | ~seen);
      end
      pnf_per_byte <= compare_valid;
      pnf_persist  <= persist_q;
    end
  end

endmodule

`default_nettype wire

/* src/sdram_traffic_gen.sv */
//----------------------------------------------------------------------------
// SDRAM traffic generator top
// drives the burst command port and reports per-lane pass flags
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sdram_traffic_gen (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                local_ready,
  input  logic [mem_geom_pkg::data_width-1:0] local_rdata,
  input  logic                                local_rdata_valid,
  output traffic_pkg::local_cmd_t             cmd,
  output logic [mem_geom_pkg::lane_count-1:0] pnf_per_byte,
  output logic                                pnf_persist,
  output traffic_pkg::test_status_t           status
);

  import mem_geom_pkg::*;
  import traffic_pkg::*;

  local_cmd_t            cmd_ctl;
  beat_evt_t             evt;
  mem_addr_t             addr;
  logic                  beat_last;
  logic                  sweep_end;
  logic                  reads_idle;
  logic                  sweep_restart;
  logic                  pattern_restart;
  logic                  mask_restart;
  logic                  zero_fill;
  logic [data_width-1:0] lane_data;
  logic [lane_count-1:0] be;

  traffic_fsm u_fsm (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .beat_last         (beat_last),
    .sweep_end         (sweep_end),
    .reads_idle        (reads_idle),
    .cmd_ctl           (cmd_ctl),
    .evt               (evt),
    .sweep_restart     (sweep_restart),
    .pattern_restart   (pattern_restart),
    .mask_restart      (mask_restart),
    .zero_fill         (zero_fill),
    .status            (status)
  );

  addr_sweep_counter u_sweep (
    .clk           (clk),
    .reset_n       (reset_n),
    .evt           (evt),
    .read_pass     (cmd_ctl.read_req),
    .sweep_restart (sweep_restart),
    .addr          (addr),
    .beat_last     (beat_last),
    .sweep_end     (sweep_end),
    .reads_idle    (reads_idle)
  );

  pattern_gen u_pattern (
    .clk             (clk),
    .reset_n         (reset_n),
    .evt             (evt),
    .pattern_restart (pattern_restart),
    .mask_restart    (mask_restart),
    .zero_fill       (zero_fill),
    .mask_mode       (status.mask_mode),
    .lane_data       (lane_data),
    .be              (be)
  );

  read_checker u_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .rd_beat      (evt.rd_beat),
    .lane_data    (lane_data),
    .be           (be),
    .local_rdata  (local_rdata),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

  // control bits from the FSM, payload from the generators
  always_comb
  begin
    cmd       = cmd_ctl;
    cmd.addr  = addr;
    cmd.be    = be;
    cmd.wdata = zero_fill ? '0 : lane_data;
  end

endmodule

`default_nettype wire

/* sim/tb_sdram_traffic_gen.sv */
//----------------------------------------------------------------------------
// testbench for the SDRAM traffic generator
// burst memory model with random back-pressure, reference model and checks
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_traffic_gen;

  import mem_geom_pkg::*;
  import traffic_pkg::*;

  localparam int reset_cycles = 3;
  localparam int read_latency = 4;
  localparam int pass_bursts  = 80;
  // 800 transfer beats x 2.5 for stalls x 4 for margin
  localparam int timeout_cycles = 8000;
  // flipped byte sits in bank 1 row 2 col 8 beat 0
  localparam logic [25:0] corrupt_key = {2'd1, 13'd2, 10'd8, 1'b0};

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [31:0]           due;
  } rd_resp_t;

  typedef struct packed {
    logic                  valid;
    logic [lane_count-1:0] ok;
  } beat_result_t;

  logic                  clk;
  logic                  reset_n;
  logic                  local_ready;
  logic [data_width-1:0] local_rdata;
  logic                  local_rdata_valid;
  local_cmd_t            cmd;
  logic [lane_count-1:0] pnf_per_byte;
  logic                  pnf_persist;
  test_status_t          status;

  logic [31:0]           rng;
  int                    cycle;
  int                    run_cycles;
  bit                    corrupt_run;
  traffic_state_t        phase;
  int                    pass_beats;
  int                    rd_ret;
  mem_addr_t             exp_addr;
  logic [3:0][7:0]       wr_lanes;
  logic [3:0][7:0]       rd_lanes;
  logic [lane_count-1:0] wr_be;
  logic [lane_count-1:0] rd_be;
  logic [data_width-1:0] mem [logic [25:0]];
  rd_resp_t              resp_q [$];
  beat_result_t          result_pipe [0:3];
  logic [lane_count-1:0] exp_pnf;
  logic                  exp_persist;
  bit                    result_seen;
  bit                    fault_seen;
  logic [lane_count-1:0] miss_lanes;
  int                    miss_count;
  local_cmd_t            prev_cmd;
  bit                    prev_stall;
  bit                    complete_seen;

  sdram_traffic_gen u_dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .cmd               (cmd),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .status            (status)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //--------------------------------------------------------------------------
  // reference functions
  //--------------------------------------------------------------------------
  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] next_rng_state(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // x^8 + x^6 + x^5 + x^4
  function automatic logic [7:0] lane_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [lane_count-1:0] walk_be(input logic [lane_count-1:0] b);
    return {b[lane_count-2:0], b[lane_count-1]};
  endfunction

  // column first, then row, then bank
  function automatic mem_addr_t next_addr(input mem_addr_t a);
    mem_addr_t r;
    bit        col_wrap;
    bit        row_wrap;
    col_wrap = (a.col == col_width'(max_col));
    row_wrap = col_wrap && (a.row == row_width'(max_row));
    r.col    = col_wrap ? '0 : a.col + col_width'(col_step);
    r.row    = !col_wrap ? a.row : (row_wrap ? '0 : a.row + 1'b1);
    r.bank   = !row_wrap ? a.bank :
               ((a.bank == bank_width'(max_bank)) ? '0 : a.bank + 1'b1);
    return r;
  endfunction

  //--------------------------------------------------------------------------
  // error handling
  //--------------------------------------------------------------------------
  task automatic stop_on_error();
    begin
      $display("Test FAILED");
      $fatal(1, "simulation stopped at the first error");
    end
  endtask

  task automatic check_value(input string name, input logic [71:0] got,
                             input logic [71:0] expected);
    begin
      assert (got === expected)
      else
      begin
        $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, expected);
        stop_on_error();
      end
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    begin
      assert (cond === 1'b1)
      else
      begin
        $display("error at %0t ns: %s", $time, what);
        stop_on_error();
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // monitor tasks run at the falling edge
  //--------------------------------------------------------------------------
  task automatic clear_model();
    int i;
    begin
      mem.delete();
      resp_q.delete();
      phase         = seq_write;
      pass_beats    = 0;
      rd_ret        = 0;
      exp_addr      = '0;
      exp_pnf       = '1;
      exp_persist   = 1'b0;
      result_seen   = 1'b0;
      fault_seen    = 1'b0;
      miss_lanes    = '0;
      miss_count    = 0;
      prev_stall    = 1'b0;
      complete_seen = 1'b0;
      for (i = 0; i < 4; i++)
        result_pipe[i] = '0;
    end
  endtask

  // a stalled request must not move
  task automatic check_hold();
    begin
      if (prev_stall)
      begin
        check_value("cmd control while stalled",
                    {cmd.write_req, cmd.read_req, cmd.burst_begin, cmd.addr, cmd.size},
                    {prev_cmd.write_req, prev_cmd.read_req, prev_cmd.burst_begin,
                     prev_cmd.addr, prev_cmd.size});
        if (prev_cmd.write_req)
          check_value("cmd payload while stalled", {cmd.be, cmd.wdata},
                      {prev_cmd.be, prev_cmd.wdata});
      end
      prev_stall = (cmd.write_req || cmd.read_req) && !local_ready;
      prev_cmd   = cmd;
    end
  endtask

  task automatic check_status();
    begin
      check_true(!(status.seq_mode && status.mask_mode),
                 "seq_mode and mask_mode are high together");
      if (status.complete)
      begin
        check_true(phase == done && rd_ret == 2 * pass_bursts * burst_len
                   && resp_q.size() == 0, "complete rose before the mask test was read back");
        check_true(!cmd.write_req && !cmd.read_req, "request issued after complete");
        complete_seen = 1'b1;
      end
      else
        check_true(!complete_seen, "complete dropped before reset");
    end
  endtask

  task automatic take_write();
    logic [data_width-1:0] exp_data;
    logic [data_width-1:0] word;
    logic [25:0]           key;
    int                    beat;
    int                    i;
    begin
      check_true(phase == seq_write || phase == mask_zero || phase == mask_write,
                 "write beat accepted outside a write pass");
      if (phase == mask_zero)
        check_true(rd_ret == pass_bursts * burst_len && resp_q.size() == 0,
                   "mask test started before the sequential reads drained");
      if (pass_beats == 0)
      begin
        exp_addr = '0;
        wr_lanes = lane_seeds;
        wr_be    = (phase == mask_write) ? lane_count'(1) : '1;
      end
      beat     = pass_beats % burst_len;
      exp_data = (phase == mask_zero) ? '0 : wr_lanes;
      check_value("cmd.addr", cmd.addr, exp_addr);
      check_value("cmd.burst_begin", cmd.burst_begin, beat == 0);
      check_value("cmd.size", cmd.size, burst_len);
      check_value("cmd.be", cmd.be, wr_be);
      check_value("cmd.wdata", cmd.wdata, exp_data);
      check_value("status.seq_mode", status.seq_mode, phase == seq_write);
      check_value("status.mask_mode", status.mask_mode, phase != seq_write);
      // merge the enabled bytes into the stored word
      key  = {cmd.addr, beat[0]};
      word = mem.exists(key) ? mem[key] : '0;
      for (i = 0; i < lane_count; i++)
        if (cmd.be[i])
          word[i*8 +: 8] = cmd.wdata[i*8 +: 8];
      if (corrupt_run && phase == seq_write && key == corrupt_key)
        word[23:16] = ~word[23:16];
      mem[key] = word;
      if (phase != mask_zero)
        for (i = 0; i < lane_count; i++)
          wr_lanes[i] = lane_next(wr_lanes[i]);
      if (phase == mask_write)
        wr_be = walk_be(wr_be);
      if (beat == burst_len - 1)
        exp_addr = next_addr(exp_addr);
      pass_beats++;
      if (pass_beats == pass_bursts * burst_len)
      begin
        check_value("last write burst addr", cmd.addr,
                    {bank_width'(max_bank), row_width'(max_row), col_width'(max_col)});
        pass_beats = 0;
        if (phase == seq_write)
          phase = seq_read;
        else if (phase == mask_zero)
          phase = mask_write;
        else
          phase = mask_read;
      end
    end
  endtask

  task automatic take_read();
    logic [25:0] key;
    rd_resp_t    rsp;
    int          k;
    begin
      check_true(phase == seq_read || phase == mask_read,
                 "read request accepted outside a read pass");
      if (pass_beats == 0)
        exp_addr = '0;
      check_value("cmd.addr", cmd.addr, exp_addr);
      check_value("cmd.burst_begin", cmd.burst_begin, 1'b1);
      check_value("cmd.size", cmd.size, burst_len);
      check_value("status.seq_mode", status.seq_mode, phase == seq_read);
      check_value("status.mask_mode", status.mask_mode, phase == mask_read);
      for (k = 0; k < burst_len; k++)
      begin
        key = {cmd.addr, k[0]};
        check_true(mem.exists(key), "read from an address that was never written");
        rsp.data = mem[key];
        rsp.due  = cycle + 1 + read_latency + k;
        resp_q.push_back(rsp);
      end
      exp_addr = next_addr(exp_addr);
      pass_beats++;
      if (pass_beats == pass_bursts)
      begin
        check_value("last read burst addr", cmd.addr,
                    {bank_width'(max_bank), row_width'(max_row), col_width'(max_col)});
        pass_beats = 0;
        phase      = (phase == seq_read) ? mask_zero : done;
      end
    end
  endtask

  // expected pass flags follow each read beat by three edges
  task automatic track_result();
    logic [lane_count-1:0] ok;
    logic [7:0]            exp_byte;
    int                    i;
    begin
      for (i = 3; i > 0; i--)
        result_pipe[i] = result_pipe[i-1];
      result_pipe[0] = '0;
      if (local_rdata_valid)
      begin
        if (rd_ret == 0 || rd_ret == pass_bursts * burst_len)
        begin
          rd_lanes = lane_seeds;
          rd_be    = (rd_ret == 0) ? '1 : lane_count'(1);
        end
        for (i = 0; i < lane_count; i++)
        begin
          exp_byte    = rd_lanes[i] & {8{rd_be[i]}};
          ok[i]       = (local_rdata[i*8 +: 8] === exp_byte);
          rd_lanes[i] = lane_next(rd_lanes[i]);
        end
        if (rd_ret >= pass_bursts * burst_len)
          rd_be = walk_be(rd_be);
        miss_lanes     = miss_lanes | ~ok;
        miss_count     = miss_count + lane_count - $countones(ok);
        rd_ret         = rd_ret + 1;
        result_pipe[0] = {1'b1, ok};
      end
      if (result_pipe[3].valid)
      begin
        exp_pnf     = result_pipe[3].ok;
        result_seen = 1'b1;
        if (exp_pnf != '1)
          fault_seen = 1'b1;
      end
      // high after the first result until any lane misses
      exp_persist = result_seen && !fault_seen;
      check_value("pnf_per_byte", pnf_per_byte, exp_pnf);
      check_value("pnf_persist", pnf_persist, exp_persist);
    end
  endtask

  always @(negedge clk)
  begin : monitor
    if (!reset_n)
      clear_model();
    else
    begin
      check_hold();
      check_status();
      if (cmd.write_req && local_ready)
        take_write();
      if (cmd.read_req && local_ready)
        take_read();
      track_result();
    end
  end

  //--------------------------------------------------------------------------
  // inputs change 5 ns after the rising edge
  //--------------------------------------------------------------------------
  always @(posedge clk)
  begin : driver
    logic     rst_now;
    logic     first_bit;
    rd_resp_t rsp;
    rst_now    = reset_n;
    cycle      = cycle + 1;
    run_cycles = rst_now ? run_cycles + 1 : 0;
    if (run_cycles > timeout_cycles)
    begin
      $display("timeout: status.complete not seen within %0d cycles", timeout_cycles);
      stop_on_error();
    end
    else
    begin
      #5;
      // ready unless both taken bits are zero
      rng         = next_rng_state(rng);
      first_bit   = rng[0];
      rng         = next_rng_state(rng);
      local_ready = first_bit | rng[0];
      if (rst_now && resp_q.size() != 0 && resp_q[0].due <= cycle)
      begin
        rsp               = resp_q.pop_front();
        local_rdata       = rsp.data;
        local_rdata_valid = 1'b1;
      end
      else
      begin
        local_rdata       = '0;
        local_rdata_valid = 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // run control
  //--------------------------------------------------------------------------
  task automatic run_once(input bit corrupt);
    begin
      @(posedge clk);
      #5;
      reset_n     = 1'b0;
      corrupt_run = corrupt;
      repeat (reset_cycles) @(posedge clk);
      #5;
      reset_n = 1'b1;
      wait (status.complete === 1'b1);
      // complete must hold with the port quiet
      repeat (10) @(posedge clk);
      check_value("pnf_per_byte", pnf_per_byte, {lane_count{1'b1}});
      check_value("pnf_persist", pnf_persist, !corrupt);
      check_value("lane miss map", miss_lanes, corrupt ? 4'b0100 : 4'b0000);
      check_value("lane miss count", miss_count, corrupt ? 1 : 0);
    end
  endtask

  initial
  begin : main
    clk               = 1'b0;
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    rng               = 32'h9a1c_6c5e;
    cycle             = 0;
    run_cycles        = 0;
    corrupt_run       = 1'b0;
    run_once(1'b0);
    // second run with one byte of lane 2 damaged in memory
    run_once(1'b1);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
src/mem_geom_pkg.sv
src/traffic_pkg.sv
src/traffic_fsm.sv
src/addr_sweep_counter.sv
src/pattern_gen.sv
src/read_checker.sv
src/sdram_traffic_gen.sv
sim/tb_sdram_traffic_gen.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram_traffic_gen
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
